/* src/mandel_pkg.sv */
package mandel_pkg;

  localparam int FX_W      = 32;
  localparam int FRAC_BITS = 24;  // Q8.24
  localparam int ITER_W    = 16;
  localparam int TAG_W     = 8;

  // signed fixed point, 8 integer bits incl. sign
  typedef logic signed [FX_W-1:0] fx_t;

  // one point from the client
  typedef struct packed {
    fx_t              cx;
    fx_t              cy;
    logic [TAG_W-1:0] tag;
  } mandel_req_t;

  // item state, travels around the iteration loop
  typedef struct packed {
    fx_t               zx;
    fx_t               zy;
    fx_t               cx;
    fx_t               cy;
    logic [ITER_W-1:0] iter;
    logic [TAG_W-1:0]  tag;
    logic              escaped;  // |z|^2 went past 4.0
    logic              done;     // finished, retire on return
  } mandel_ctx_t;

  // what the consumer gets back
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ITER_W-1:0] iter;
    logic              escaped;
  } mandel_res_t;

  // credit init sequence, then normal operation
  typedef enum logic {
    ST_CREDIT_INIT,
    ST_RUN
  } ctrl_state_e;

endpackage

/* src/fx_mult.sv */
`timescale 1ns/10ps

module fx_mult
  import mandel_pkg::*;
#(
  parameter int LAT = 3
) (
  input  logic clk_i,
  input  logic rst_i,
  input  fx_t  a_i,
  input  fx_t  b_i,
  output fx_t  p_o
);

  logic signed [2*FX_W-1:0] full;    // raw Q16.48 product
  logic signed [2*FX_W-1:0] scaled;
  fx_t                      pipe_q [LAT];

  assign full   = a_i * b_i;
  assign scaled = full >>> FRAC_BITS;  // back to Q8.24, floor

  // delay line, retimed into the multiplier by synthesis
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < LAT; i++)
      begin
        pipe_q[i] <= '0;
      end
    end
    else
    begin
      pipe_q[0] <= scaled[FX_W-1:0];  // top bits dropped
      for (int i = 1; i < LAT; i++)
      begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign p_o = pipe_q[LAT-1];

endmodule

/* src/mandel_iter.sv */
`timescale 1ns/10ps

module mandel_iter
  import mandel_pkg::*;
#(
  parameter int MUL_LAT = 3
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [ITER_W-1:0] max_iter_i,
  input  logic              in_valid_i,
  input  mandel_ctx_t       in_ctx_i,
  output logic              out_valid_o,
  output mandel_ctx_t       out_ctx_o
);

  // escape threshold 4.0, one bit wider than fx_t like the sum
  localparam logic signed [FX_W:0] ESC_LIM = 4 << FRAC_BITS;

  fx_t                  xx;  // zx^2
  fx_t                  yy;  // zy^2
  fx_t                  xy;  // zx*zy
  fx_t                  xy2;
  logic signed [FX_W:0] mag;
  logic                 vld_q [MUL_LAT];
  mandel_ctx_t          ctx_q [MUL_LAT];
  mandel_ctx_t          ctx_d;
  mandel_ctx_t          nxt_ctx;

  fx_mult #(
    .LAT (MUL_LAT)
  ) u_mul_xx (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .a_i   (in_ctx_i.zx),
    .b_i   (in_ctx_i.zx),
    .p_o   (xx)
  );

  fx_mult #(
    .LAT (MUL_LAT)
  ) u_mul_yy (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .a_i   (in_ctx_i.zy),
    .b_i   (in_ctx_i.zy),
    .p_o   (yy)
  );

  fx_mult #(
    .LAT (MUL_LAT)
  ) u_mul_xy (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .a_i   (in_ctx_i.zx),
    .b_i   (in_ctx_i.zy),
    .p_o   (xy)
  );

  // valid bits of the context delay line
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < MUL_LAT; i++)
      begin
        vld_q[i] <= 1'b0;
      end
    end
    else
    begin
      vld_q[0] <= in_valid_i;
      for (int i = 1; i < MUL_LAT; i++)
      begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // context rides alongside the multipliers
  always_ff @(posedge clk_i)
  begin
    ctx_q[0] <= in_ctx_i;
    for (int i = 1; i < MUL_LAT; i++)
    begin
      ctx_q[i] <= ctx_q[i-1];
    end
  end

  assign ctx_d = ctx_q[MUL_LAT-1];  // lines up with xx, yy, xy
  assign mag   = {xx[FX_W-1], xx} + {yy[FX_W-1], yy};
  assign xy2   = xy <<< 1;

  // pass rule
  always_comb
  begin
    nxt_ctx = ctx_d;
    if (!ctx_d.done)
    begin
      if (mag > ESC_LIM)
      begin
        nxt_ctx.escaped = 1'b1;  // z and iter kept as they were
        nxt_ctx.done    = 1'b1;
      end
      else if (ctx_d.iter == max_iter_i)
      begin
        nxt_ctx.done = 1'b1;     // bounded
      end
      else
      begin
        nxt_ctx.zx   = xx - yy + ctx_d.cx;
        nxt_ctx.zy   = xy2 + ctx_d.cy;
        nxt_ctx.iter = ctx_d.iter + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      out_valid_o <= 1'b0;
    end
    else
    begin
      out_valid_o <= vld_q[MUL_LAT-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    out_ctx_o <= nxt_ctx;
  end

endmodule

/* src/pixel_ctrl.sv */
`timescale 1ns/10ps

module pixel_ctrl
  import mandel_pkg::*;
#(
  parameter int SLOTS       = 8,
  parameter int RES_CREDITS = 4,
  parameter int MUL_LAT     = 3
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_valid_i,
  input  mandel_req_t req_i,
  output logic        req_credit_o,
  input  logic        res_credit_i,
  output logic        res_valid_o,
  output mandel_res_t res_o,
  output logic        iter_valid_o,
  output mandel_ctx_t iter_ctx_o,
  input  logic        ret_valid_i,
  input  mandel_ctx_t ret_ctx_i
);

  localparam int PTR_W  = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam int CNT_W  = $clog2(SLOTS + 1);
  localparam int CRED_W = $clog2(RES_CREDITS + 1);  // consumer only returns what it took

  // the loop through mandel_iter needs at least one register per pass
  if (MUL_LAT < 1)
  begin : g_lat_check
    $error("pixel_ctrl: MUL_LAT must be at least 1");
  end

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(SLOTS - 1)) ? '0 : p + 1'b1;
  endfunction

  ctrl_state_e       state_q;
  logic [CNT_W-1:0]  init_cnt_q;
  logic              init_pulse_q;

  mandel_req_t       iq_mem [SLOTS];  // waiting requests
  logic [PTR_W-1:0]  iq_wr_q;
  logic [PTR_W-1:0]  iq_rd_q;
  logic [CNT_W-1:0]  iq_cnt_q;
  mandel_req_t       iq_head;

  mandel_res_t       rq_mem [SLOTS];  // finished, waiting for a credit
  logic [PTR_W-1:0]  rq_wr_q;
  logic [PTR_W-1:0]  rq_rd_q;
  logic [CNT_W-1:0]  rq_cnt_q;

  logic [CRED_W-1:0] res_cred_q;
  logic              reissue;
  logic              retire;
  logic              take_new;
  logic              res_fire;

  assign reissue  = ret_valid_i & ~ret_ctx_i.done;  // always wins the slot
  assign retire   = ret_valid_i &  ret_ctx_i.done;
  assign take_new = ~reissue & (iq_cnt_q != '0);
  assign iq_head  = iq_mem[iq_rd_q];

  always_comb
  begin
    iter_ctx_o = ret_ctx_i;
    if (!reissue)
    begin
      iter_ctx_o     = '0;  // fresh item, z = 0, iter = 0
      iter_ctx_o.cx  = iq_head.cx;
      iter_ctx_o.cy  = iq_head.cy;
      iter_ctx_o.tag = iq_head.tag;
    end
  end

  assign iter_valid_o = reissue | take_new;

  // results held back until the init pulses are out
  assign res_fire     = (rq_cnt_q != '0) & (res_cred_q != '0) & (state_q == ST_RUN);
  assign res_valid_o  = res_fire;
  assign res_o        = rq_mem[rq_rd_q];
  assign req_credit_o = init_pulse_q | res_fire;  // a slot frees as a result leaves

  // request credit init: SLOTS pulses, then run
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q      <= ST_CREDIT_INIT;
      init_cnt_q   <= '0;
      init_pulse_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_CREDIT_INIT:
        begin
          if (init_cnt_q == CNT_W'(SLOTS))
          begin
            state_q      <= ST_RUN;
            init_pulse_q <= 1'b0;
          end
          else
          begin
            init_pulse_q <= 1'b1;
            init_cnt_q   <= init_cnt_q + 1'b1;
          end
        end
        default:
        begin
          init_pulse_q <= 1'b0;
        end
      endcase
    end
  end

  // queue pointers and credit counter
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      iq_wr_q    <= '0;
      iq_rd_q    <= '0;
      iq_cnt_q   <= '0;
      rq_wr_q    <= '0;
      rq_rd_q    <= '0;
      rq_cnt_q   <= '0;
      res_cred_q <= CRED_W'(RES_CREDITS);
    end
    else
    begin
      if (req_valid_i)
      begin
        iq_wr_q <= ptr_inc(iq_wr_q);  // client holds a credit, never full
      end
      if (take_new)
      begin
        iq_rd_q <= ptr_inc(iq_rd_q);
      end
      if (retire)
      begin
        rq_wr_q <= ptr_inc(rq_wr_q);
      end
      if (res_fire)
      begin
        rq_rd_q <= ptr_inc(rq_rd_q);
      end
      iq_cnt_q   <= iq_cnt_q + CNT_W'(req_valid_i) - CNT_W'(take_new);
      rq_cnt_q   <= rq_cnt_q + CNT_W'(retire) - CNT_W'(res_fire);
      res_cred_q <= res_cred_q + CRED_W'(res_credit_i) - CRED_W'(res_fire);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_valid_i)
    begin
      iq_mem[iq_wr_q] <= req_i;
    end
    if (retire)
    begin
      rq_mem[rq_wr_q] <= '{tag: ret_ctx_i.tag, iter: ret_ctx_i.iter, escaped: ret_ctx_i.escaped};
    end
  end

endmodule

/* src/mandel_top.sv */
`timescale 1ns/10ps

module mandel_top
  import mandel_pkg::*;
#(
  parameter int MUL_LAT     = 3,
  parameter int SLOTS       = 8,
  parameter int RES_CREDITS = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [ITER_W-1:0] max_iter_i,
  input  logic              req_valid_i,
  input  mandel_req_t       req_i,
  output logic              req_credit_o,
  input  logic              res_credit_i,
  output logic              res_valid_o,
  output mandel_res_t       res_o
);

  logic        iter_valid;  // into the pass pipeline
  mandel_ctx_t iter_ctx;
  logic        out_valid;   // back from it, MUL_LAT + 1 later
  mandel_ctx_t out_ctx;

  pixel_ctrl #(
    .SLOTS       (SLOTS),
    .RES_CREDITS (RES_CREDITS),
    .MUL_LAT     (MUL_LAT)
  ) u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .res_credit_i (res_credit_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .iter_valid_o (iter_valid),
    .iter_ctx_o   (iter_ctx),
    .ret_valid_i  (out_valid),
    .ret_ctx_i    (out_ctx)
  );

  mandel_iter #(
    .MUL_LAT (MUL_LAT)
  ) u_iter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .max_iter_i  (max_iter_i),
    .in_valid_i  (iter_valid),
    .in_ctx_i    (iter_ctx),
    .out_valid_o (out_valid),
    .out_ctx_o   (out_ctx)
  );

endmodule

/* tb/mandel_assertions.sv */
`timescale 1ns/10ps

module mandel_assertions
  import mandel_pkg::*;
#(
  parameter int SLOTS       = 8,
  parameter int RES_CREDITS = 4
) (
  input logic        clk_i,
  input logic        rst_i,
  input logic        req_valid_i,
  input logic        req_credit_i,
  input logic        res_valid_i,
  input logic        res_credit_i,
  input ctrl_state_e state_i,
  input logic        ret_valid_i,
  input logic        ret_done_i,
  input logic        iter_valid_i,
  input logic        iter_done_i
);

  int occ_q;        // items between request and result
  int init_seen_q;  // credit pulses during init
  int cred_q;       // result credits granted by the consumer, not yet used
  int fail_cnt = 0;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      occ_q       <= 0;
      init_seen_q <= 0;
      cred_q      <= RES_CREDITS;
    end
    else
    begin
      occ_q  <= occ_q + (req_valid_i ? 1 : 0) - (res_valid_i ? 1 : 0);
      cred_q <= cred_q + (res_credit_i ? 1 : 0) - (res_valid_i ? 1 : 0);
      if (state_i == ST_CREDIT_INIT && req_credit_i)
        init_seen_q <= init_seen_q + 1;
    end
  end

  a_res_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_i |-> cred_q > 0)
  else
  begin
    $error("result sent without a result credit");
    fail_cnt++;
  end

  a_occupancy: assert property (@(posedge clk_i) disable iff (rst_i)
    occ_q <= SLOTS)
  else
  begin
    $error("more than SLOTS items inside pixel_ctrl");
    fail_cnt++;
  end

  a_init_pulses: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_i == ST_CREDIT_INIT && req_credit_i) |-> init_seen_q < SLOTS)
  else
  begin
    $error("too many request credit pulses during init");
    fail_cnt++;
  end

  a_no_reissue: assert property (@(posedge clk_i) disable iff (rst_i)
    (ret_valid_i && ret_done_i) |-> !(iter_valid_i && iter_done_i))
  else
  begin
    $error("finished item sent back into the pipeline");
    fail_cnt++;
  end

endmodule

bind pixel_ctrl mandel_assertions #(
  .SLOTS       (SLOTS),
  .RES_CREDITS (RES_CREDITS)
) u_assert (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .req_valid_i  (req_valid_i),
  .req_credit_i (req_credit_o),
  .res_valid_i  (res_valid_o),
  .res_credit_i (res_credit_i),
  .state_i      (state_q),
  .ret_valid_i  (ret_valid_i),
  .ret_done_i   (ret_ctx_i.done),
  .iter_valid_i (iter_valid_o),
  .iter_done_i  (iter_ctx_o.done)
);

/* tb/mandel_tb.sv */
`timescale 1ns/10ps

module mandel_tb
  import mandel_pkg::*;
();

  localparam int MUL_LAT     = 3;
  localparam int SLOTS       = 8;
  localparam int RES_CREDITS = 4;
  localparam int N_SWEEP     = 4;
  localparam int MAX_IT_HI   = 64;
  localparam int N_REQ       = 3 + 3 * SLOTS + 2 * N_SWEEP;
  localparam int TIMEOUT     = N_REQ * (MAX_IT_HI + 1) * (MUL_LAT + 1 + SLOTS) + 2000;
  localparam fx_t ONE        = 32'sh0100_0000;
  localparam longint ESC4    = 64'sd4 <<< FRAC_BITS;  // 4.0 in Q8.24

  logic              clk_i;
  logic              rst_i;
  logic [ITER_W-1:0] max_iter;
  logic              req_valid;
  mandel_req_t       req;
  logic              req_credit;
  logic              res_credit;
  logic              res_valid;
  mandel_res_t       res;

  int errors, checks, asrt_fails, cycles;
  int req_credits, pending_cred, outstanding, results_seen;
  bit grant_en;  // consumer hands credits back
  logic [31:0] lfsr_q;
  logic [TAG_W-1:0] next_tag;
  bit exp_live [2**TAG_W];  // scoreboard by tag
  int exp_iter [2**TAG_W];
  bit exp_esc  [2**TAG_W];
  int got_iter [2**TAG_W];
  bit got_esc  [2**TAG_W];

  mandel_top #(
    .MUL_LAT     (MUL_LAT),
    .SLOTS       (SLOTS),
    .RES_CREDITS (RES_CREDITS)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .max_iter_i   (max_iter),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_credit_o (req_credit),
    .res_credit_i (res_credit),
    .res_valid_o  (res_valid),
    .res_o        (res)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];  // x^32+x^22+x^2+x+1
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // signed 26-bit value from -2.0 up to just under 2.0
  function automatic fx_t rand_coord();
    logic [25:0] v;
    for (int i = 0; i < 26; i++)
      v[i] = lfsr_bit();
    return fx_t'({{6{v[25]}}, v});
  endfunction

  // escape count of one point by plain iteration
  task automatic model(input fx_t cx, input fx_t cy, input int max_it,
                       output int it, output bit esc);
    fx_t    zx;
    fx_t    zy;
    longint xx, yy, xy;
    bit     fin;
    zx  = '0;
    zy  = '0;
    it  = 0;
    esc = 1'b0;
    fin = 1'b0;
    while (!fin)
    begin
      xx = (longint'(zx) * longint'(zx)) >>> FRAC_BITS;
      yy = (longint'(zy) * longint'(zy)) >>> FRAC_BITS;
      xy = (longint'(zx) * longint'(zy)) >>> FRAC_BITS;
      if (xx + yy > ESC4)
      begin
        esc = 1'b1;
        fin = 1'b1;
      end
      else if (it == max_it)
        fin = 1'b1;
      else
      begin
        zx = fx_t'(xx - yy + longint'(cx));
        zy = fx_t'(2 * xy + longint'(cy));
        it++;
      end
    end
  endtask

  task automatic check(input int got, input int exp, input string msg);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("error at %0d ns: %s, got %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic step(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic send_req(input fx_t cx, input fx_t cy, output logic [TAG_W-1:0] tag);
    int it;
    bit esc;
    while (req_credits == 0)
      step(1);
    model(cx, cy, int'(max_iter), it, esc);
    tag           = next_tag;
    next_tag      = next_tag + 1'b1;
    exp_live[tag] = 1'b1;
    exp_iter[tag] = it;
    exp_esc[tag]  = esc;
    outstanding++;
    req_credits--;
    req_valid = 1'b1;
    req       = '{cx: cx, cy: cy, tag: tag};
    step(1);
    req_valid = 1'b0;
  endtask

  task automatic take_result(input mandel_res_t r);
    if (!exp_live[r.tag])
    begin
      errors++;
      $display("error at %0d ns: tag %0d came back but was not outstanding", $time, r.tag);
    end
    else
    begin
      check(int'(r.iter), exp_iter[r.tag], $sformatf("iter of tag %0d", r.tag));
      check(int'(r.escaped), int'(exp_esc[r.tag]), $sformatf("escaped of tag %0d", r.tag));
      exp_live[r.tag] = 1'b0;
      got_iter[r.tag] = int'(r.iter);
      got_esc[r.tag]  = r.escaped;
      outstanding--;
    end
    results_seen++;
    pending_cred++;
  endtask

  task automatic drain();
    wait (outstanding == 0 && pending_cred == 0);
    step(2);
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (req_credit)
        req_credits++;
      if (res_valid)
        take_result(res);
    end
  end

  always @(posedge clk_i)
  begin
    #2;
    if (grant_en && pending_cred > 0)
    begin
      res_credit = 1'b1;
      pending_cred--;
    end
    else
      res_credit = 1'b0;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > TIMEOUT)
    begin
      $display("timeout: %0d cycles passed and %0d results never came back", cycles, outstanding);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic reset_credits();
    step(SLOTS + 4);
    check(req_credits, SLOTS, "request credits after reset");
    check(results_seen, 0, "results before any request");
  endtask

  task automatic fixed_points();
    logic [TAG_W-1:0] t0, t1, t2;
    max_iter = 16'd20;
    send_req('0, '0, t0);
    send_req(2 * ONE, '0, t1);
    send_req(-2 * ONE, '0, t2);
    drain();
    check(got_iter[t0], 20, "c = 0 count");
    check(int'(got_esc[t0]), 0, "c = 0 escaped");
    check(got_iter[t1], 2, "c = 2.0 count");
    check(int'(got_esc[t1]), 1, "c = 2.0 escaped");
    check(got_iter[t2], 20, "c = -2.0 count");
    check(int'(got_esc[t2]), 0, "c = -2.0 escaped");
  endtask

  task automatic send_random(input int n);
    fx_t cx, cy;
    logic [TAG_W-1:0] t;
    for (int i = 0; i < n; i++)
    begin
      cx = rand_coord();
      cy = rand_coord();
      send_req(cx, cy, t);
    end
  endtask

  task automatic random_batch();
    int seen0;
    seen0    = results_seen;
    max_iter = 16'd32;
    send_random(2 * SLOTS);  // second half paced by returning credits
    drain();
    check(results_seen - seen0, 2 * SLOTS, "results of random batch");
    check(req_credits, SLOTS, "request credits after batch");
  endtask

  task automatic result_backpressure();
    int seen0;
    seen0    = results_seen;
    grant_en = 1'b0;
    send_random(SLOTS);
    wait (results_seen - seen0 == RES_CREDITS);
    step(SLOTS * (int'(max_iter) + 2) + 50);  // long enough for every item to finish
    check(results_seen - seen0, RES_CREDITS, "results while credits withheld");
    check(req_credits, RES_CREDITS, "request credits while credits withheld");
    grant_en = 1'b1;
    drain();
    check(results_seen - seen0, SLOTS, "results after credits granted");
    check(req_credits, SLOTS, "request credits after back-pressure");
  endtask

  task automatic limit_sweep();
    fx_t cx [N_SWEEP];
    fx_t cy [N_SWEEP];
    int esc_at [N_SWEEP];  // escape count, 0 when bounded
    logic [TAG_W-1:0] ta [N_SWEEP];
    logic [TAG_W-1:0] tb [N_SWEEP];
    cx[0]     = '0;
    cy[0]     = '0;
    esc_at[0] = 0;
    cx[1]     = -ONE;  // bounded 2-cycle
    cy[1]     = '0;
    esc_at[1] = 0;
    cx[2]     = ONE;
    cy[2]     = ONE;
    esc_at[2] = 2;
    cx[3]     = ONE / 2;
    cy[3]     = '0;
    esc_at[3] = 5;
    max_iter = 16'd16;
    for (int i = 0; i < N_SWEEP; i++)
      send_req(cx[i], cy[i], ta[i]);
    drain();
    max_iter = 16'(MAX_IT_HI);
    for (int i = 0; i < N_SWEEP; i++)
      send_req(cx[i], cy[i], tb[i]);
    drain();
    for (int i = 0; i < N_SWEEP; i++)
    begin
      if (esc_at[i] != 0)
      begin
        check(got_iter[ta[i]], esc_at[i], $sformatf("sweep point %0d low limit count", i));
        check(got_iter[tb[i]], esc_at[i], $sformatf("sweep point %0d count kept", i));
      end
      else
      begin
        check(got_iter[ta[i]], 16, $sformatf("sweep point %0d low limit", i));
        check(got_iter[tb[i]], MAX_IT_HI, $sformatf("sweep point %0d high limit", i));
      end
      check(int'(got_esc[tb[i]]), int'(esc_at[i] != 0), $sformatf("sweep point %0d escaped", i));
    end
  endtask

  initial
  begin
    rst_i      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    res_credit = 1'b0;
    max_iter   = 16'd20;
    grant_en   = 1'b1;
    lfsr_q     = 32'h604f_2066;
    next_tag   = '0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    reset_credits();
    fixed_points();
    random_batch();
    result_backpressure();
    limit_sweep();
    step(4);
    asrt_fails = u_dut.u_ctrl.u_assert.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* filelist.f */
src/mandel_pkg.sv
src/fx_mult.sv
src/mandel_iter.sv
src/pixel_ctrl.sv
src/mandel_top.sv
tb/mandel_assertions.sv
tb/mandel_tb.sv

/* run.sh */
#!/bin/sh
# build and run the Mandelbrot testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mandel_tb -f filelist.f -o mandel_sim

./obj_dir/mandel_sim +verilator+error+limit+100 | tee sim.log

if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run passed"
